/* env_step.f */
env_step_pkg.sv
result_packer.sv
env_step_array.sv
step_sequencer.sv
env_step_top.sv
tb_env_step.sv

/* tb_env_step.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_env_step
    import env_step_pkg::*;
;

    localparam int NUM_FIXED  = 5;
    localparam int NUM_RAND   = 10;
    localparam int NUM_ROWS   = NUM_FIXED + NUM_RAND;
    localparam int ROW_CYCLES = 200; // generous bound for one command
    localparam int RST_CYCLES = 10;
    localparam int IDLE_WAIT  = 50;

    // one host command and the words it should leave in the ram
    typedef struct packed {
        logic [DATA_WL-1:0] flag;
        logic [DATA_WL-1:0] sta;
        logic [DATA_WL-1:0] act;
        logic [DATA_WL-1:0] obs;
        logic [DATA_WL-1:0] rwd;
        logic [DATA_WL-1:0] done;
    } row_s;

    logic               i_clk;
    logic               i_rstn;
    logic [DATA_WL-1:0] ram_rdata;
    logic [DATA_WL-1:0] o_data;
    logic [ADDR_WL-1:0] o_addr;
    logic               o_en;
    logic               o_wea;

    logic [DATA_WL-1:0] mem [16]; // host side ram
    logic [ADDR_WL-1:0] rd_addr;
    int                 wr_cnt;
    int                 flag_wr_cnt; // flag word writes seen
    int                 poll_cnt;

    row_s               tbl [$];
    logic [31:0]        rng_state;
    logic signed [7:0]  mdl_pos  [ENV_NUM];
    logic signed [7:0]  mdl_init [ENV_NUM];
    logic               mdl_loaded;

    env_step_top uut (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_data  (ram_rdata),
        .o_data  (o_data),
        .o_addr  (o_addr),
        .o_en    (o_en),
        .o_wea   (o_wea)
    );

    always #10 i_clk = ~i_clk;

    // read data follows the registered address, one cycle after o_en
    assign ram_rdata = mem[rd_addr];

    always @(posedge i_clk) begin
        if (o_en === 1'b1 && o_wea === 1'b1) begin
            mem[o_addr] <= o_data;
            wr_cnt      <= wr_cnt + 1;
            if (o_addr == FLAG_ADDR) begin
                flag_wr_cnt <= flag_wr_cnt + 1;
            end
        end else if (o_en === 1'b1) begin
            rd_addr <= o_addr;
            if (o_addr == FLAG_ADDR) begin
                poll_cnt <= poll_cnt + 1;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // 0 moves down, 2 moves up, 1 and 3 hold
    function automatic int move_delta(input logic [1:0] a);
        int d;
        case (a)
            2'd0:    d = -1;
            2'd2:    d = 1;
            default: d = 0;
        endcase
        return d;
    endfunction

    task automatic check(input logic [DATA_WL-1:0] got, input logic [DATA_WL-1:0] exp,
                         input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // reference step, also keeps the held and initial states
    task automatic model_step(input row_s r, output row_s e);
        int   p;
        logic fin;
        e      = r;
        e.obs  = '0;
        e.rwd  = '0;
        e.done = '0;
        if (r.flag == CLR_FLAG || !mdl_loaded) begin
            for (int i = 0; i < ENV_NUM; i++) begin
                mdl_pos[i]  = r.sta[8*i +: 8];
                mdl_init[i] = r.sta[8*i +: 8];
            end
            mdl_loaded = 1'b1;
        end
        for (int i = 0; i < ENV_NUM; i++) begin
            p                = mdl_pos[i] + move_delta(r.act[2*i +: 2]);
            fin              = (p > POS_LIMIT) || (p < -POS_LIMIT);
            e.obs[8*i +: 8]  = p[7:0];
            e.rwd[i]         = !fin;
            e.done[i]        = fin;
            mdl_pos[i]       = fin ? mdl_init[i] : p[7:0];
        end
    endtask

    task automatic build_table();
        row_s scratch;
        row_s r;
        // clear, then steps that push lanes 3 and 4 past the bound and back
        tbl.push_back('{flag: 64'd2, sta: 64'h01CE329C64F60A00, act: 64'hFFFF00000000_2F52,
                        obs: 64'h00CF329C64F60901, rwd: 64'hFF, done: 64'h00});
        tbl.push_back('{flag: 64'd1, sta: 64'h7F7F7F7F7F7F7F7F, act: 64'h123400000000_9089,
                        obs: 64'h01CF319B65F50A01, rwd: 64'hE7, done: 64'h18});
        tbl.push_back('{flag: 64'd3, sta: 64'h8181818181818181, act: 64'h0000000000005615,
                        obs: 64'h01CF319D63F50A01, rwd: 64'hFF, done: 64'h00});
        // second clear replaces held and initial states
        tbl.push_back('{flag: 64'd2, sta: 64'h059C64000000EC14, act: 64'h000000000000C952,
                        obs: 64'h059B65000000EB15, rwd: 64'h9F, done: 64'h60});
        tbl.push_back('{flag: 64'd1, sta: 64'h0000000000000000, act: 64'h0000000000005555,
                        obs: 64'h059C64000000EB15, rwd: 64'hFF, done: 64'h00});
        for (int k = 0; k < NUM_FIXED; k++) begin
            model_step(tbl[k], scratch); // bring the model up to date
        end
        for (int k = 0; k < NUM_RAND; k++) begin
            rng_state    = xorshift32(rng_state);
            r.act[31:0]  = rng_state;
            rng_state    = xorshift32(rng_state);
            r.act[63:32] = rng_state; // pad bits, ignored
            rng_state    = xorshift32(rng_state);
            r.sta        = {rng_state, ~rng_state}; // must not be used
            rng_state    = xorshift32(rng_state);
            r.flag       = rng_state[0] ? 64'd3 : 64'd1;
            model_step(r, scratch);
            tbl.push_back(scratch);
        end
    endtask

    task automatic wait_flag_clear(input int row);
        int start;
        int n;
        start = flag_wr_cnt;
        n     = 0;
        while (flag_wr_cnt == start && n < ROW_CYCLES) begin
            @(posedge i_clk);
            n++;
        end
        if (flag_wr_cnt == start) begin
            $display("Row %0d: the DUT never wrote the flag word back", row);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic apply_row(input int idx, input row_s r);
        @(negedge i_clk);
        mem[STA_ADDR]  = r.sta;
        mem[ACT_ADDR]  = r.act;
        mem[OBS_ADDR]  = 64'hDEAD_BEEF_0000_0000 | idx; // stale results show up
        mem[RWD_ADDR]  = 64'hDEAD_BEEF_0000_0000 | idx;
        mem[DONE_ADDR] = 64'hDEAD_BEEF_0000_0000 | idx;
        mem[FLAG_ADDR] = r.flag;
        wait_flag_clear(idx);
        @(negedge i_clk);
        check(mem[OBS_ADDR], r.obs, $sformatf("row %0d obs", idx));
        check(mem[RWD_ADDR], r.rwd, $sformatf("row %0d rwd", idx));
        check(mem[DONE_ADDR], r.done, $sformatf("row %0d done", idx));
        check(mem[FLAG_ADDR], '0, $sformatf("row %0d flag", idx));
    endtask

    initial begin
        repeat (RST_CYCLES + IDLE_WAIT + 20 + NUM_ROWS * ROW_CYCLES) @(posedge i_clk);
        $display("Watchdog expired before all rows were applied");
        $display("Some tests failed");
        $fatal(1);
    end

    initial begin
        int start;
        i_clk       = 1'b0;
        i_rstn      = 1'b0;
        rd_addr     = '0;
        wr_cnt      = 0;
        flag_wr_cnt = 0;
        poll_cnt    = 0;
        rng_state   = 32'hb17fa6ef;
        mdl_loaded  = 1'b0;
        for (int a = 0; a < 16; a++) begin
            mem[a] = {16{a[3:0]}};
        end
        mem[FLAG_ADDR] = '0;
        build_table();

        repeat (RST_CYCLES) begin
            @(negedge i_clk);
            check(o_wea, 1'b0, "o_wea in reset");
        end
        i_rstn = 1'b1;

        // zero flag, the engine only polls
        start = wr_cnt;
        repeat (IDLE_WAIT) begin
            @(negedge i_clk);
            check(o_wea, 1'b0, "o_wea while idle");
        end
        check(wr_cnt, start, "write count while idle");
        check(poll_cnt != 0, 1'b1, "flag polling after reset");

        for (int k = 0; k < NUM_ROWS; k++) begin
            apply_row(k, tbl[k]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* env_step_top.sv */
`timescale 1ns/1ps
`default_nettype none

module env_step_top
    import env_step_pkg::*;
(
    input  wire logic               i_clk,
    input  wire logic               i_rstn,
    input  wire logic [DATA_WL-1:0] i_data, // ram read data, one cycle after o_en
    output logic      [DATA_WL-1:0] o_data,
    output logic      [ADDR_WL-1:0] o_addr,
    output logic                    o_en,
    output logic                    o_wea   // one word per strobe
);

    logic          load_sta;
    logic          load_act;
    logic          step;
    logic          res_valid; // step result strobe
    step_res_s     step_res;
    result_words_s res_words; // held for the write-back

    step_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_data      (i_data),
        .i_res_valid (res_valid),
        .i_res       (res_words),
        .o_addr      (o_addr),
        .o_en        (o_en),
        .o_wea       (o_wea),
        .o_data      (o_data),
        .o_load_sta  (load_sta),
        .o_load_act  (load_act),
        .o_step      (step)
    );

    env_step_array u_array (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_word      (i_data),
        .i_load_sta  (load_sta),
        .i_load_act  (load_act),
        .i_step      (step),
        .o_res_valid (res_valid),
        .o_res       (step_res)
    );

    result_packer u_pack (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_valid (res_valid),
        .i_res   (step_res),
        .o_words (res_words)
    );

endmodule

`default_nettype wire

/* step_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module step_sequencer
    import env_step_pkg::*;
(
    input  wire logic          i_clk,
    input  wire logic          i_rstn,
    input  wire mem_word_u     i_data,      // ram read word
    input  wire logic          i_res_valid, // from step array
    input  wire result_words_s i_res,       // from packer, valid a cycle after i_res_valid
    output logic [ADDR_WL-1:0] o_addr,
    output logic               o_en,
    output logic               o_wea,
    output logic [DATA_WL-1:0] o_data,
    output logic               o_load_sta,
    output logic               o_load_act,
    output logic               o_step
);

    logic [2:0]         state_q;
    logic [2:0]         state_d;
    logic               ph_q;     // 0 = issue read, 1 = data on i_data
    logic               loaded_q; // held states valid since reset
    logic [DATA_WL-1:0] flag_w;
    logic               clr_cmd;

    assign flag_w = i_data;

    // nothing held yet means any command has to load states first
    assign clr_cmd = (flag_w == CLR_FLAG) || !loaded_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ph_q && flag_w != '0) begin
                    state_d = clr_cmd ? RD_STA : RD_ACT;
                end
            end
            RD_STA: begin
                if (ph_q) begin
                    state_d = RD_ACT;
                end
            end
            RD_ACT: begin
                state_d = WAIT_RES;
            end
            WAIT_RES: begin
                if (i_res_valid) begin
                    state_d = WR_OBS; // packer words ready next cycle
                end
            end
            WR_OBS: begin
                state_d = WR_RWD;
            end
            WR_RWD: begin
                state_d = WR_DONE;
            end
            WR_DONE: begin
                state_d = WR_FLAG;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state_q  <= IDLE;
            ph_q     <= 1'b0;
            loaded_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // phase only runs in the two-cycle read states
            if (state_d == state_q && (state_q == IDLE || state_q == RD_STA)) begin
                ph_q <= ~ph_q;
            end else begin
                ph_q <= 1'b0;
            end
            if (o_load_sta) begin
                loaded_q <= 1'b1;
            end
        end
    end

    // the capture half of every read also fetches the action word,
    // so RD_ACT always finds it on i_data
    always_comb begin
        o_en       = 1'b0;
        o_wea      = 1'b0;
        o_addr     = FLAG_ADDR;
        o_data     = '0;
        o_load_sta = 1'b0;
        o_load_act = 1'b0;
        o_step     = 1'b0;
        case (state_q)
            IDLE: begin
                o_en   = 1'b1;
                o_addr = ph_q ? ACT_ADDR : FLAG_ADDR; // flag sampled on ph 1
            end
            RD_STA: begin
                o_en       = 1'b1;
                o_addr     = ph_q ? ACT_ADDR : STA_ADDR;
                o_load_sta = ph_q;
            end
            RD_ACT: begin
                o_load_act = 1'b1;
                o_step     = 1'b1; // array uses the action a cycle later
            end
            WR_OBS: begin
                o_en   = 1'b1;
                o_wea  = 1'b1;
                o_addr = OBS_ADDR;
                o_data = i_res.obs;
            end
            WR_RWD: begin
                o_en   = 1'b1;
                o_wea  = 1'b1;
                o_addr = RWD_ADDR;
                o_data = i_res.rwd;
            end
            WR_DONE: begin
                o_en   = 1'b1;
                o_wea  = 1'b1;
                o_addr = DONE_ADDR;
                o_data = i_res.done;
            end
            WR_FLAG: begin
                o_en  = 1'b1;
                o_wea = 1'b1; // zero flag hands the ram back
            end
            default: begin
                o_en = 1'b0;
            end
        endcase
    end

    // a read issued last cycle still owns the port
    a_no_wr_in_rd: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (o_en && !o_wea) |=> !o_wea)
        else $error("write issued while a read is in flight");

endmodule

`default_nettype wire

/* env_step_array.sv */
`timescale 1ns/1ps
`default_nettype none

module env_step_array
    import env_step_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rstn,
    input  wire mem_word_u i_word,     // ram word, decoded by strobe
    input  wire logic      i_load_sta, // sets held and initial states
    input  wire logic      i_load_act,
    input  wire logic      i_step,
    output logic           o_res_valid,
    output step_res_s      o_res
);

    pos_t               pos_q  [ENV_NUM]; // held state
    pos_t               init_q [ENV_NUM]; // captured at last clear
    act_t               act_q  [ENV_NUM];
    pos_t               nxt_q  [ENV_NUM]; // stage one result
    logic               v1_q;
    logic               v2_q;
    logic [ENV_NUM-1:0] lane_done;

    function automatic pos_t act_delta(act_t a);
        pos_t d;
        case (a)
            ACT_DEC: d = pos_t'(-1);
            ACT_INC: d = pos_t'(1);
            default: d = '0; // hold
        endcase
        return d;
    endfunction

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= i_step;
            v2_q <= v1_q;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < ENV_NUM; i++) begin
            if (i_load_act) begin
                act_q[i] <= i_word.act.lane[i];
            end
            if (v1_q) begin
                nxt_q[i] <= pos_q[i] + act_delta(act_q[i]); // stage one
            end
            if (i_load_sta) begin
                pos_q[i]  <= i_word.sta[i];
                init_q[i] <= i_word.sta[i];
            end else if (v2_q) begin
                // finished lanes restart from the initial state
                pos_q[i] <= lane_done[i] ? init_q[i] : nxt_q[i];
            end
        end
    end

    // stage two bound check
    always_comb begin
        for (int i = 0; i < ENV_NUM; i++) begin
            lane_done[i] = (nxt_q[i] > POS_LIMIT) || (nxt_q[i] < -POS_LIMIT);
        end
    end

    always_comb begin
        for (int i = 0; i < ENV_NUM; i++) begin
            o_res.nxt[i] = nxt_q[i];
        end
        o_res.done = lane_done;
    end

    assign o_res_valid = v2_q;

    // pipeline holds one step only
    a_one_step: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_step |=> !i_step [*STEP_LATENCY])
        else $error("step strobe while a step is in flight");

endmodule

`default_nettype wire

/* result_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module result_packer
    import env_step_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rstn,
    input  wire logic      i_valid, // one cycle per step
    input  wire step_res_s i_res,
    output result_words_s  o_words  // stays put until the next step
);

    logic [DATA_WL-1:0] obs_w;
    logic [DATA_WL-1:0] rwd_w;
    logic [DATA_WL-1:0] done_w;

    // lane i in byte i
    always_comb begin
        obs_w = '0;
        for (int i = 0; i < ENV_NUM; i++) begin
            obs_w[i*POS_WL +: POS_WL] = i_res.nxt[i];
        end
    end

    // reward 1 while the episode runs
    assign rwd_w  = {{(DATA_WL-ENV_NUM){1'b0}}, ~i_res.done};
    assign done_w = {{(DATA_WL-ENV_NUM){1'b0}}, i_res.done};

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_words <= '0;
        end else if (i_valid) begin
            o_words.obs  <= obs_w;
            o_words.rwd  <= rwd_w;
            o_words.done <= done_w;
        end
    end

    // step array must present clean lanes with its strobe
    a_res_known: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_valid |-> !$isunknown(i_res))
        else $error("unknown step result with valid");

endmodule

`default_nettype wire

/* env_step_pkg.sv */
`default_nettype none

package env_step_pkg;

    // ram port and array shape
    localparam int DATA_WL = 64;      // one ram word
    localparam int ENV_NUM = 8;       // environments, one lane each
    localparam int POS_WL  = 8;       // signed position per lane
    localparam int ACT_WL  = 2;
    localparam int ADDR_WL = 4;       // word address

    // word map shared with the host
    localparam logic [ADDR_WL-1:0] STA_ADDR  = 4'd0; // initial states
    localparam logic [ADDR_WL-1:0] ACT_ADDR  = 4'd1; // actions
    localparam logic [ADDR_WL-1:0] FLAG_ADDR = 4'd2; // start flag, polled
    localparam logic [ADDR_WL-1:0] OBS_ADDR  = 4'd3;
    localparam logic [ADDR_WL-1:0] RWD_ADDR  = 4'd4;
    localparam logic [ADDR_WL-1:0] DONE_ADDR = 4'd5;

    localparam logic [DATA_WL-1:0] CLR_FLAG = 64'd2; // reload states, then step

    localparam int POS_LIMIT    = 100; // episode ends outside +-limit
    localparam int STEP_LATENCY = 2;   // step strobe to result strobe

    // action encodings, 1 and 3 both hold
    localparam logic [ACT_WL-1:0] ACT_DEC = 2'd0;
    localparam logic [ACT_WL-1:0] ACT_INC = 2'd2;

    // sequencer states
    localparam logic [2:0] IDLE     = 3'd0; // poll flag
    localparam logic [2:0] RD_STA   = 3'd1; // read state word, two cycles
    localparam logic [2:0] RD_ACT   = 3'd2; // capture action word, fire step
    localparam logic [2:0] WAIT_RES = 3'd3;
    localparam logic [2:0] WR_OBS   = 3'd4;
    localparam logic [2:0] WR_RWD   = 3'd5;
    localparam logic [2:0] WR_DONE  = 3'd6;
    localparam logic [2:0] WR_FLAG  = 3'd7; // clear flag, back to poll

    typedef logic signed [POS_WL-1:0] pos_t;
    typedef logic [ACT_WL-1:0] act_t;

    // action lanes sit in the low bits of the word
    typedef struct packed {
        logic [DATA_WL-ENV_NUM*ACT_WL-1:0] pad;
        act_t [ENV_NUM-1:0]                lane;
    } act_word_s;

    // a read word is either a state word or an action word
    typedef union packed {
        pos_t [ENV_NUM-1:0] sta; // lane 0 in the lowest byte
        act_word_s          act;
    } mem_word_u;

    // step array output, 72 bits
    typedef struct packed {
        pos_t [ENV_NUM-1:0] nxt;
        logic [ENV_NUM-1:0] done;
    } step_res_s;

    // words written back to the host, 192 bits
    typedef struct packed {
        logic [DATA_WL-1:0] obs;
        logic [DATA_WL-1:0] rwd;
        logic [DATA_WL-1:0] done;
    } result_words_s;

endpackage

`default_nettype wire
